// File: draw_buttons.f
+incdir+hdl
hdl/btn_pkg.sv
hdl/btn_if.sv
hdl/btn_decode.sv
hdl/btn_glyph.sv
hdl/btn_paint.sv
hdl/draw_buttons.sv
sim/draw_buttons_assert.sv
sim/draw_buttons_tb.sv

// File: hdl/btn_decode.sv
// First overlay stage, one cycle; button priority is first, second, third, central
module btn_decode import btn_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [HCOUNT_W-1:0] hcount,
    input  logic [VCOUNT_W-1:0] vcount,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                hblnk,
    input  logic                vblnk,
    input  logic [RGB_W-1:0]    rgb,
    input  game_state_e         state,
    input  logic                deal_wait,
    input  logic [1:0]          selected_player,
    input  logic                dealer_finished,
    pixel_if.src                tim,
    btn_hit_if.src              hit
);

    logic                on_bottom;
    logic                on_col1;
    logic                on_col2;
    logic                on_col3;
    logic                on_central;
    logic                central_off;
    btn_id_e             btn_nxt;
    logic [RGB_W-1:0]    body_nxt;
    logic [HCOUNT_W-1:0] x_base;
    logic [VCOUNT_W-1:0] y_base;

    assign on_bottom  = (vcount >= BOTTOM_Y) && (vcount < BOTTOM_Y + BOTTOM_H);
    assign on_col1    = (hcount >= BTN1_X) && (hcount < BTN1_X + BOTTOM_W);
    assign on_col2    = (hcount >= BTN2_X) && (hcount < BTN2_X + BOTTOM_W);
    assign on_col3    = (hcount >= BTN3_X) && (hcount < BTN3_X + BOTTOM_W);
    assign on_central = (hcount >= CENTRAL_X) && (hcount < CENTRAL_X + CENTRAL_W) &&
                        (vcount >= CENTRAL_Y) && (vcount < CENTRAL_Y + CENTRAL_H);

    // Menu ignores the dealer, the result screens wait for it
    assign central_off = (!dealer_finished && state != st_menu) ||
                         (selected_player == NO_PLAYER);

    always_comb begin
        btn_nxt  = btn_none;
        body_nxt = COL_GREY;
        x_base   = hcount;                       // Zero offset off the buttons
        y_base   = vcount;
        if (on_bottom && on_col1 && state == st_deal) begin
            btn_nxt  = btn_first;
            body_nxt = (selected_player == NO_PLAYER) ? COL_GREY : COL_RED;
            x_base   = BTN1_X;
            y_base   = BOTTOM_Y;
        end else if (on_bottom && on_col2 && state == st_play) begin
            btn_nxt  = btn_second;
            body_nxt = deal_wait ? COL_GREY : COL_BLUE;
            x_base   = BTN2_X;
            y_base   = BOTTOM_Y;
        end else if (on_bottom && on_col3 && state == st_play) begin
            btn_nxt  = btn_third;
            body_nxt = deal_wait ? COL_GREY : COL_GREEN;
            x_base   = BTN3_X;
            y_base   = BOTTOM_Y;
        end else if (on_central && state inside {st_menu, st_dealer, st_win, st_lose}) begin
            btn_nxt  = btn_central;
            body_nxt = central_off ? COL_GREY : COL_ORANGE;
            x_base   = CENTRAL_X;
            y_base   = CENTRAL_Y;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tim.hcount <= '0;
            tim.vcount <= '0;
            tim.hsync  <= 1'b0;
            tim.vsync  <= 1'b0;
            tim.hblnk  <= 1'b0;
            tim.vblnk  <= 1'b0;
            tim.rgb    <= '0;
            hit.btn    <= btn_none;
            hit.dx     <= '0;
            hit.dy     <= '0;
            hit.body   <= '0;
        end else begin
            tim.hcount <= hcount;
            tim.vcount <= vcount;
            tim.hsync  <= hsync;
            tim.vsync  <= vsync;
            tim.hblnk  <= hblnk;
            tim.vblnk  <= vblnk;
            tim.rgb    <= rgb;
            hit.btn    <= btn_nxt;
            hit.dx     <= OFS_W'(hcount - x_base);  // Local offsets fit in OFS_W
            hit.dy     <= OFS_W'(vcount - y_base);
            hit.body   <= body_nxt;
        end
    end

endmodule

// File: hdl/btn_glyph.sv
// Combinational stroke lookup; the table is searched in full every pixel, no ordering among strokes
module btn_glyph import btn_pkg::*; (
    btn_hit_if.dst hit,
    output logic   ink
);

    always_comb begin
        ink = 1'b0;
        for (int i = 0; i < STROKE_N; i++) begin
            if (hit.btn != btn_none &&
                    STROKES[i].btn == hit.btn &&
                    hit.dx >= STROKES[i].x_lo && hit.dx <= STROKES[i].x_hi &&
                    hit.dy >= STROKES[i].y_lo && hit.dy <= STROKES[i].y_hi) begin
                ink = 1'b1;                      // Strokes may overlap
            end
        end
    end

endmodule

// File: hdl/btn_if.sv
// Internal links between overlay stages; all signals are sampled every clock, no handshake

interface pixel_if import btn_pkg::*; ();

    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                hsync;
    logic                vsync;
    logic                hblnk;
    logic                vblnk;
    logic [RGB_W-1:0]    rgb;

    modport src (output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);
    modport dst (input  hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);

endinterface

interface btn_hit_if import btn_pkg::*; ();

    btn_id_e          btn;                       // Button under the pixel
    logic [OFS_W-1:0] dx;                        // Offset from the button corner
    logic [OFS_W-1:0] dy;
    logic [RGB_W-1:0] body;                      // Already shaded for the disable rule

    modport src (output btn, dx, dy, body);
    modport dst (input  btn, dx, dy, body);

endinterface

// File: hdl/btn_paint.sv
// Result stage, one cycle; all outputs read 0 while reset is held
module btn_paint import btn_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    pixel_if.dst                tim,
    btn_hit_if.dst              hit,
    input  logic                ink,
    output logic [HCOUNT_W-1:0] hcount_out,
    output logic [VCOUNT_W-1:0] vcount_out,
    output logic                hsync_out,
    output logic                vsync_out,
    output logic                hblnk_out,
    output logic                vblnk_out,
    output logic [RGB_W-1:0]    rgb_out
);

    logic [RGB_W-1:0] rgb_nxt;

    always_comb begin
        if (ink) begin
            rgb_nxt = COL_INK;
        end else if (hit.btn != btn_none) begin
            rgb_nxt = hit.body;
        end else begin
            rgb_nxt = tim.rgb;                   // Background passes through
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= tim.hcount;
            vcount_out <= tim.vcount;
            hsync_out  <= tim.hsync;
            vsync_out  <= tim.vsync;
            hblnk_out  <= tim.hblnk;
            vblnk_out  <= tim.vblnk;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

// File: hdl/btn_pkg.sv
// Shared widths, geometry, colours and types of the button overlay; geometry assumes 11-bit counts
package btn_pkg;

    localparam int HCOUNT_W = 11;
    localparam int VCOUNT_W = 11;
    localparam int RGB_W    = 12;                // 4 bits per channel
    localparam int OFS_W    = 8;                 // Covers the widest button

    // Bottom row of buttons
    localparam logic [HCOUNT_W-1:0] BTN1_X   = 11'd342;
    localparam logic [HCOUNT_W-1:0] BTN2_X   = 11'd462;
    localparam logic [HCOUNT_W-1:0] BTN3_X   = 11'd582;
    localparam logic [VCOUNT_W-1:0] BOTTOM_Y = 11'd668;
    localparam logic [HCOUNT_W-1:0] BOTTOM_W = 11'd100;
    localparam logic [VCOUNT_W-1:0] BOTTOM_H = 11'd50;

    // Central button, centred on the table
    localparam logic [HCOUNT_W-1:0] CENTRAL_X = 11'd422;
    localparam logic [VCOUNT_W-1:0] CENTRAL_Y = 11'd370;
    localparam logic [HCOUNT_W-1:0] CENTRAL_W = 11'd120;
    localparam logic [VCOUNT_W-1:0] CENTRAL_H = 11'd60;

    localparam logic [RGB_W-1:0] COL_RED    = 12'hF00;
    localparam logic [RGB_W-1:0] COL_BLUE   = 12'h00F;
    localparam logic [RGB_W-1:0] COL_GREEN  = 12'h0F0;
    localparam logic [RGB_W-1:0] COL_ORANGE = 12'hF72;
    localparam logic [RGB_W-1:0] COL_GREY   = 12'hAAA;  // Disabled button body
    localparam logic [RGB_W-1:0] COL_INK    = 12'h000;  // Letter strokes

    localparam logic [1:0] NO_PLAYER = 2'd3;

    typedef enum logic [2:0] {
        st_menu   = 3'd0,
        st_deal   = 3'd1,
        st_play   = 3'd2,
        st_dealer = 3'd3,
        st_win    = 3'd4,
        st_lose   = 3'd5,
        st_select = 3'd6                         // Overlay is idle here
    } game_state_e;

    typedef enum logic [2:0] {
        btn_none,
        btn_first,
        btn_second,
        btn_third,
        btn_central
    } btn_id_e;

    // One inclusive rectangle in button-local coordinates
    typedef struct packed {
        btn_id_e          btn;
        logic [OFS_W-1:0] x_lo;
        logic [OFS_W-1:0] x_hi;
        logic [OFS_W-1:0] y_lo;
        logic [OFS_W-1:0] y_hi;
    } stroke_t;

    localparam int STROKE_N = 60;

`include "btn_strokes.svh"

endpackage

// File: hdl/btn_strokes.svh
// Letter strokes of the four buttons as inclusive local offsets, included only inside btn_pkg
`ifndef BTN_STROKES_SVH
`define BTN_STROKES_SVH

localparam stroke_t STROKES [STROKE_N] = '{
    '{btn_first,   8'd11,  8'd15,  8'd5,  8'd45},  // D
    '{btn_first,   8'd11,  8'd27,  8'd5,  8'd9},
    '{btn_first,   8'd25,  8'd29,  8'd7,  8'd43},
    '{btn_first,   8'd11,  8'd27,  8'd41, 8'd45},
    '{btn_first,   8'd31,  8'd35,  8'd5,  8'd45},  // E
    '{btn_first,   8'd31,  8'd49,  8'd5,  8'd9},
    '{btn_first,   8'd31,  8'd49,  8'd23, 8'd27},
    '{btn_first,   8'd31,  8'd49,  8'd41, 8'd45},
    '{btn_first,   8'd51,  8'd55,  8'd7,  8'd45},  // A
    '{btn_first,   8'd65,  8'd69,  8'd7,  8'd45},
    '{btn_first,   8'd53,  8'd67,  8'd5,  8'd9},
    '{btn_first,   8'd51,  8'd67,  8'd23, 8'd27},
    '{btn_first,   8'd71,  8'd75,  8'd5,  8'd43},  // L
    '{btn_first,   8'd71,  8'd89,  8'd41, 8'd45},
    '{btn_second,  8'd21,  8'd25,  8'd5,  8'd45},  // H
    '{btn_second,  8'd35,  8'd39,  8'd5,  8'd45},
    '{btn_second,  8'd21,  8'd39,  8'd23, 8'd27},
    '{btn_second,  8'd48,  8'd52,  8'd5,  8'd45},  // I
    '{btn_second,  8'd61,  8'd79,  8'd5,  8'd9},   // T
    '{btn_second,  8'd68,  8'd72,  8'd5,  8'd45},
    '{btn_third,   8'd6,   8'd22,  8'd5,  8'd9},   // S
    '{btn_third,   8'd6,   8'd22,  8'd23, 8'd27},
    '{btn_third,   8'd6,   8'd22,  8'd41, 8'd45},
    '{btn_third,   8'd6,   8'd10,  8'd7,  8'd23},
    '{btn_third,   8'd18,  8'd22,  8'd27, 8'd43},
    '{btn_third,   8'd24,  8'd40,  8'd5,  8'd9},   // T
    '{btn_third,   8'd30,  8'd34,  8'd5,  8'd45},
    '{btn_third,   8'd44,  8'd54,  8'd5,  8'd9},   // A
    '{btn_third,   8'd44,  8'd56,  8'd23, 8'd27},
    '{btn_third,   8'd42,  8'd46,  8'd7,  8'd45},
    '{btn_third,   8'd52,  8'd56,  8'd7,  8'd45},
    '{btn_third,   8'd58,  8'd62,  8'd5,  8'd45},  // N, diagonal as three steps
    '{btn_third,   8'd70,  8'd74,  8'd5,  8'd45},
    '{btn_third,   8'd63,  8'd66,  8'd13, 8'd16},
    '{btn_third,   8'd67,  8'd70,  8'd17, 8'd20},
    '{btn_third,   8'd71,  8'd74,  8'd18, 8'd21},
    '{btn_third,   8'd76,  8'd80,  8'd5,  8'd45},  // D
    '{btn_third,   8'd88,  8'd92,  8'd7,  8'd43},
    '{btn_third,   8'd76,  8'd90,  8'd5,  8'd9},
    '{btn_third,   8'd76,  8'd90,  8'd41, 8'd45},
    '{btn_central, 8'd12,  8'd29,  8'd10, 8'd14},  // S
    '{btn_central, 8'd10,  8'd14,  8'd12, 8'd29},
    '{btn_central, 8'd12,  8'd28,  8'd28, 8'd32},
    '{btn_central, 8'd25,  8'd29,  8'd30, 8'd48},
    '{btn_central, 8'd10,  8'd28,  8'd46, 8'd50},
    '{btn_central, 8'd31,  8'd49,  8'd10, 8'd14},  // T
    '{btn_central, 8'd38,  8'd42,  8'd10, 8'd50},
    '{btn_central, 8'd53,  8'd67,  8'd10, 8'd14},  // A
    '{btn_central, 8'd51,  8'd69,  8'd26, 8'd30},
    '{btn_central, 8'd51,  8'd55,  8'd12, 8'd50},
    '{btn_central, 8'd65,  8'd69,  8'd12, 8'd50},
    '{btn_central, 8'd71,  8'd75,  8'd10, 8'd50},  // R
    '{btn_central, 8'd71,  8'd87,  8'd10, 8'd14},
    '{btn_central, 8'd71,  8'd87,  8'd26, 8'd30},
    '{btn_central, 8'd85,  8'd89,  8'd12, 8'd28},
    '{btn_central, 8'd75,  8'd80,  8'd30, 8'd35},  // Leg of the R
    '{btn_central, 8'd80,  8'd85,  8'd35, 8'd40},
    '{btn_central, 8'd85,  8'd89,  8'd40, 8'd50},
    '{btn_central, 8'd91,  8'd109, 8'd10, 8'd14},  // T
    '{btn_central, 8'd98,  8'd102, 8'd10, 8'd50}
};

`endif

// File: hdl/draw_buttons.sv
// Button overlay with 2-cycle latency on every output; state codes above 6 show no button
module draw_buttons import btn_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [2:0]          state,
    input  logic                deal_wait,
    input  logic [1:0]          selected_player,
    input  logic                dealer_finished,
    input  logic [HCOUNT_W-1:0] hcount,
    input  logic [VCOUNT_W-1:0] vcount,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                hblnk,
    input  logic                vblnk,
    input  logic [RGB_W-1:0]    rgb,
    output logic [HCOUNT_W-1:0] hcount_out,
    output logic [VCOUNT_W-1:0] vcount_out,
    output logic                hsync_out,
    output logic                vsync_out,
    output logic                hblnk_out,
    output logic                vblnk_out,
    output logic [RGB_W-1:0]    rgb_out
);

    pixel_if   tim_d ();
    btn_hit_if hit_d ();
    logic      ink;

    btn_decode u_decode (
        .clk             (clk),
        .rst             (rst),
        .hcount          (hcount),
        .vcount          (vcount),
        .hsync           (hsync),
        .vsync           (vsync),
        .hblnk           (hblnk),
        .vblnk           (vblnk),
        .rgb             (rgb),
        .state           (game_state_e'(state)),
        .deal_wait       (deal_wait),
        .selected_player (selected_player),
        .dealer_finished (dealer_finished),
        .tim             (tim_d.src),
        .hit             (hit_d.src)
    );

    btn_glyph u_glyph (
        .hit (hit_d.dst),
        .ink (ink)                               // Same cycle as hit_d
    );

    btn_paint u_paint (
        .clk        (clk),
        .rst        (rst),
        .tim        (tim_d.dst),
        .hit        (hit_d.dst),
        .ink        (ink),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .hblnk_out  (hblnk_out),
        .vblnk_out  (vblnk_out),
        .rgb_out    (rgb_out)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --assert --top-module draw_buttons_tb -f draw_buttons.f -o draw_buttons_sim

./obj_dir/draw_buttons_sim | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// File: sim/draw_buttons_assert.sv
// Concurrent checks bound into draw_buttons; the delay check holds only for a 2-cycle pipeline
module draw_buttons_assert import btn_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                hsync,
    input logic [HCOUNT_W-1:0] hcount_out,
    input logic [VCOUNT_W-1:0] vcount_out,
    input logic                hsync_out,
    input logic                vsync_out,
    input logic                hblnk_out,
    input logic                vblnk_out,
    input logic [RGB_W-1:0]    rgb_out
);

    property p_reset_clears;
        @(posedge clk) rst |=> (hcount_out == '0 && vcount_out == '0 && !hsync_out &&
                                !vsync_out && !hblnk_out && !vblnk_out && rgb_out == '0);
    endproperty

    property p_hsync_delay;
        @(posedge clk) disable iff (rst)
            (!$past(rst, 1) && !$past(rst, 2)) |-> (hsync_out == $past(hsync, 2));
    endproperty

    a_reset_clears: assert property (p_reset_clears)
        else $error("Outputs were not cleared one cycle after reset");

    a_hsync_delay: assert property (p_hsync_delay)
        else $error("hsync_out does not follow hsync from two cycles earlier");

endmodule

bind draw_buttons draw_buttons_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .hsync      (hsync),
    .hcount_out (hcount_out),
    .vcount_out (vcount_out),
    .hsync_out  (hsync_out),
    .vsync_out  (vsync_out),
    .hblnk_out  (hblnk_out),
    .vblnk_out  (vblnk_out),
    .rgb_out    (rgb_out)
);

// File: sim/draw_buttons_tb.sv
// Self-checking testbench for draw_buttons; assumes 2-cycle latency and timing support
module draw_buttons_tb import btn_pkg::*; ();

    logic                clk;
    logic                rst;
    logic [2:0]          state;
    logic                deal_wait;
    logic [1:0]          selected_player;
    logic                dealer_finished;
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                hsync;
    logic                vsync;
    logic                hblnk;
    logic                vblnk;
    logic [RGB_W-1:0]    rgb;
    logic [HCOUNT_W-1:0] hcount_out;
    logic [VCOUNT_W-1:0] vcount_out;
    logic                hsync_out;
    logic                vsync_out;
    logic                hblnk_out;
    logic                vblnk_out;
    logic [RGB_W-1:0]    rgb_out;

    typedef struct packed {
        logic [HCOUNT_W-1:0] hcount;
        logic [VCOUNT_W-1:0] vcount;
        logic                hsync;
        logic                vsync;
        logic                hblnk;
        logic                vblnk;
        logic [RGB_W-1:0]    rgb;
    } exp_t;

    exp_t        exp_q [$];                      // Pixels in flight, 2 deep
    logic [15:0] lfsr_state;
    int          checks;
    int          errors;
    int          timeouts;
    int          driven;
    int          checked;

    draw_buttons dut0 (.*);

    always #4 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        logic        out_bit;
        val = '0;
        for (int i = 0; i < n; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1
            end
            val = {val[14:0], out_bit};
        end
        return val;
    endfunction

    function automatic void button_box(input btn_id_e b, output int x0, output int y0,
                                       output int w, output int h);
        w = int'(BOTTOM_W);
        h = int'(BOTTOM_H);
        y0 = int'(BOTTOM_Y);
        case (b)
            btn_first:  x0 = int'(BTN1_X);
            btn_second: x0 = int'(BTN2_X);
            btn_third:  x0 = int'(BTN3_X);
            default: begin
                x0 = int'(CENTRAL_X);
                y0 = int'(CENTRAL_Y);
                w  = int'(CENTRAL_W);
                h  = int'(CENTRAL_H);
            end
        endcase
    endfunction

    function automatic logic in_box(input btn_id_e b, input int hc, input int vc);
        int x0;
        int y0;
        int w;
        int h;
        button_box(b, x0, y0, w, h);
        return (hc >= x0) && (hc < x0 + w) && (vc >= y0) && (vc < y0 + h);
    endfunction

    // Expected colour from region, state and the disable rules
    function automatic logic [RGB_W-1:0] ref_color(input logic [2:0] st, input logic dw,
            input logic [1:0] sp, input logic df, input int hc, input int vc,
            input logic [RGB_W-1:0] bg);
        btn_id_e          b;
        logic [RGB_W-1:0] color;
        int               x0;
        int               y0;
        int               w;
        int               h;
        int               dx;
        int               dy;
        b     = btn_none;
        color = bg;
        if (st == st_deal && in_box(btn_first, hc, vc)) begin
            b     = btn_first;
            color = (sp == NO_PLAYER) ? COL_GREY : COL_RED;
        end else if (st == st_play && in_box(btn_second, hc, vc)) begin
            b     = btn_second;
            color = dw ? COL_GREY : COL_BLUE;
        end else if (st == st_play && in_box(btn_third, hc, vc)) begin
            b     = btn_third;
            color = dw ? COL_GREY : COL_GREEN;
        end else if ((st == st_menu || st == st_dealer || st == st_win || st == st_lose) &&
                     in_box(btn_central, hc, vc)) begin
            b = btn_central;
            if (sp == NO_PLAYER || (st != st_menu && !df)) begin
                color = COL_GREY;
            end else begin
                color = COL_ORANGE;
            end
        end
        if (b == btn_none) begin
            return bg;
        end
        button_box(b, x0, y0, w, h);
        dx = hc - x0;
        dy = vc - y0;
        for (int i = 0; i < STROKE_N; i++) begin
            if (STROKES[i].btn == b &&
                    dx >= int'(STROKES[i].x_lo) && dx <= int'(STROKES[i].x_hi) &&
                    dy >= int'(STROKES[i].y_lo) && dy <= int'(STROKES[i].y_hi)) begin
                color = COL_INK;
            end
        end
        return color;
    endfunction

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, want);
        end
    endtask

    task automatic check_outputs(input exp_t want);
        compare_value("hcount_out", 16'(hcount_out), 16'(want.hcount));
        compare_value("vcount_out", 16'(vcount_out), 16'(want.vcount));
        compare_value("hsync_out", 16'(hsync_out), 16'(want.hsync));
        compare_value("vsync_out", 16'(vsync_out), 16'(want.vsync));
        compare_value("hblnk_out", 16'(hblnk_out), 16'(want.hblnk));
        compare_value("vblnk_out", 16'(vblnk_out), 16'(want.vblnk));
        compare_value("rgb_out", 16'(rgb_out), 16'(want.rgb));
    endtask

    task automatic drive_pixel(input logic [2:0] st, input logic dw, input logic [1:0] sp,
            input logic df, input logic [HCOUNT_W-1:0] hc, input logic [VCOUNT_W-1:0] vc);
        @(negedge clk);
        state           = st;
        deal_wait       = dw;
        selected_player = sp;
        dealer_finished = df;
        hcount          = hc;
        vcount          = vc;
        hsync           = 1'(rand_bits(1));
        vsync           = 1'(rand_bits(1));
        hblnk           = 1'(rand_bits(1));
        vblnk           = 1'(rand_bits(1));
        rgb             = 12'(rand_bits(12));
        driven++;
    endtask

    task automatic aim_button(input btn_id_e b, output logic [HCOUNT_W-1:0] hc,
                              output logic [VCOUNT_W-1:0] vc);
        int x0;
        int y0;
        int w;
        int h;
        button_box(b, x0, y0, w, h);
        hc = 11'(x0 + int'(rand_bits(7)) % w);
        vc = 11'(y0 + int'(rand_bits(6)) % h);
    endtask

    task automatic aim_stroke(output logic [HCOUNT_W-1:0] hc, output logic [VCOUNT_W-1:0] vc);
        int idx;
        int x0;
        int y0;
        int w;
        int h;
        int span_x;
        int span_y;
        idx = int'(rand_bits(6)) % STROKE_N;
        button_box(STROKES[idx].btn, x0, y0, w, h);
        span_x = int'(STROKES[idx].x_hi) - int'(STROKES[idx].x_lo) + 1;
        span_y = int'(STROKES[idx].y_hi) - int'(STROKES[idx].y_lo) + 1;
        hc = 11'(x0 + int'(STROKES[idx].x_lo) + int'(rand_bits(5)) % span_x);
        vc = 11'(y0 + int'(STROKES[idx].y_lo) + int'(rand_bits(6)) % span_y);
    endtask

    initial begin : compare_proc
        exp_t e;
        forever begin
            @(posedge clk);
            if (rst) begin
                exp_q.delete();
            end else begin
                e.hcount = hcount;
                e.vcount = vcount;
                e.hsync  = hsync;
                e.vsync  = vsync;
                e.hblnk  = hblnk;
                e.vblnk  = vblnk;
                e.rgb    = ref_color(state, deal_wait, selected_player, dealer_finished,
                                     int'(hcount), int'(vcount), rgb);
                exp_q.push_back(e);
            end
            @(negedge clk);
            if (exp_q.size() == 1) begin
                check_outputs('0);               // First cycle out of reset
            end else if (exp_q.size() == 2) begin
                check_outputs(exp_q.pop_front());
                checked++;
            end
        end
    end

    initial begin : stimulus
        logic [HCOUNT_W-1:0] hc;
        logic [VCOUNT_W-1:0] vc;
        logic [2:0]          st;
        logic                dw;
        logic [1:0]          sp;
        logic                df;
        int                  wait_cycles;
        clk             = 1'b0;
        rst             = 1'b1;
        state           = '0;
        deal_wait       = 1'b0;
        selected_player = '0;
        dealer_finished = 1'b0;
        hcount          = '0;
        vcount          = '0;
        hsync           = 1'b0;
        vsync           = 1'b0;
        hblnk           = 1'b0;
        vblnk           = 1'b0;
        rgb             = '0;
        lfsr_state      = 16'd74;
        checks          = 0;
        errors          = 0;
        timeouts        = 0;
        driven          = 0;
        checked         = 0;
        repeat (5) begin                         // Busy inputs that reset must mask
            drive_pixel(3'(rand_bits(3)), 1'(rand_bits(1)), 2'(rand_bits(2)),
                        1'(rand_bits(1)), 11'(rand_bits(11)), 11'(rand_bits(11)));
        end
        rst    = 1'b0;
        driven = 0;                              // Pixel held at release is the extra one
        for (int r = 0; r < 64; r++) begin
            st = 3'(r % 8);                      // Includes select and unused codes
            dw = 1'(rand_bits(1));
            sp = 2'(rand_bits(2));
            df = 1'(rand_bits(1));
            repeat (4) begin
                hc = 11'(rand_bits(11));
                vc = 11'(rand_bits(11));
                drive_pixel(st, dw, sp, df, hc, vc);
            end
            for (int b = 1; b <= 4; b++) begin
                aim_button(btn_id_e'(3'(b)), hc, vc);
                drive_pixel(st, dw, sp, df, hc, vc);
            end
            repeat (3) begin
                aim_stroke(hc, vc);
                drive_pixel(st, dw, sp, df, hc, vc);
            end
        end
        wait_cycles = 0;
        while (checked <= driven && wait_cycles < 16) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (checked <= driven) begin
            timeouts++;
            $display("Timeout while waiting for the last pixels to leave the pipeline");
        end
        $display("Checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
